/* source/arp_tx_pkg.sv */
package arp_tx_pkg;

  typedef logic [47:0] mac_addr_t;   // Sent most significant byte first
  typedef logic [31:0] ipv4_addr_t;  // Sent most significant byte first
  typedef logic [31:0] crc_t;
  typedef logic [7:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [3:0]  axil_strb_t;
  typedef logic [1:0]  axil_resp_t;

  typedef struct packed {
    mac_addr_t  src_mac;
    ipv4_addr_t src_ip;
    ipv4_addr_t dst_ip;
  } arp_cfg_t;

  // Preamble and SFD bytes are kept out of the CRC
  typedef enum logic [1:0] {
    kind_preamble,
    kind_body,
    kind_fcs
  } byte_kind_t;

  typedef struct packed {
    logic       valid;
    byte_kind_t kind;
    logic [7:0] data;
    logic [1:0] fcs_index;
  } tx_byte_t;

  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
  } axil_wr_rsp_t;

  typedef struct packed {
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_rd_req_t;

  typedef struct packed {
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rd_rsp_t;

  localparam axil_resp_t resp_okay   = 2'd0;
  localparam axil_resp_t resp_slverr = 2'd2;

  localparam axil_addr_t reg_ctrl       = 8'h00;
  localparam axil_addr_t reg_status     = 8'h04;
  localparam axil_addr_t reg_src_mac_hi = 8'h08;  // Upper 16 bits of the MAC
  localparam axil_addr_t reg_src_mac_lo = 8'h0C;
  localparam axil_addr_t reg_src_ip     = 8'h10;
  localparam axil_addr_t reg_dst_ip     = 8'h14;

  localparam int preamble_bytes = 7;
  localparam int pad_bytes      = 18;
  localparam int frame_bytes    = 72;  // Preamble and SFD through FCS

  localparam logic [7:0]  preamble_byte    = 8'h55;
  localparam logic [7:0]  sfd_byte         = 8'hD5;
  localparam mac_addr_t   broadcast_mac    = 48'hFFFF_FFFF_FFFF;
  localparam logic [15:0] ethertype_arp    = 16'h0806;
  localparam logic [15:0] arp_htype        = 16'h0001;
  localparam logic [15:0] arp_ptype        = 16'h0800;
  localparam logic [7:0]  arp_hlen         = 8'h06;
  localparam logic [7:0]  arp_plen         = 8'h04;
  localparam logic [15:0] arp_oper_request = 16'h0001;

  // Fixed part of the ARP payload in wire order
  localparam logic [63:0] arp_hdr = {arp_htype, arp_ptype, arp_hlen, arp_plen,
                                     arp_oper_request};

endpackage

/* source/arp_csr_decode.sv */
`timescale 1ns/1ps

module arp_csr_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  arp_tx_pkg::axil_wr_req_t wr_req,
  output arp_tx_pkg::axil_wr_rsp_t wr_rsp,
  input  arp_tx_pkg::axil_rd_req_t rd_req,
  output arp_tx_pkg::axil_rd_rsp_t rd_rsp,
  input  logic                     busy,
  input  logic                     frame_done,
  output arp_tx_pkg::arp_cfg_t     cfg,
  output logic                     send_req
);
  import arp_tx_pkg::*;

  logic       aw_ready;
  logic       b_valid;
  axil_resp_t b_resp;
  logic       ar_ready;
  logic       r_valid;
  axil_resp_t r_resp;
  axil_data_t r_data;
  logic       wr_hs;
  logic       rd_hs;
  logic       ctrl_go;
  logic [7:0] frames_sent;
  arp_cfg_t   cfg_q;
  axil_data_t status_word;
  axil_data_t rd_word;
  axil_data_t mac_hi_merged;
  axil_data_t mac_lo_merged;
  axil_data_t src_ip_merged;
  axil_data_t dst_ip_merged;

  function automatic logic addr_mapped(axil_addr_t addr);
    return addr inside {reg_ctrl, reg_status, reg_src_mac_hi, reg_src_mac_lo,
                        reg_src_ip, reg_dst_ip};
  endfunction

  function automatic axil_data_t merge_strb(axil_data_t old_val, axil_data_t new_val,
                                            axil_strb_t strb);
    axil_data_t res;
    res = old_val;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  assign wr_hs = aw_ready & wr_req.awvalid & wr_req.wvalid;
  assign rd_hs = ar_ready & rd_req.arvalid;

  assign mac_hi_merged = merge_strb({16'h0, cfg_q.src_mac[47:32]}, wr_req.wdata, wr_req.wstrb);
  assign mac_lo_merged = merge_strb(cfg_q.src_mac[31:0], wr_req.wdata, wr_req.wstrb);
  assign src_ip_merged = merge_strb(cfg_q.src_ip, wr_req.wdata, wr_req.wstrb);
  assign dst_ip_merged = merge_strb(cfg_q.dst_ip, wr_req.wdata, wr_req.wstrb);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      aw_ready <= 1'b0;
      b_valid  <= 1'b0;
      b_resp   <= resp_okay;
      ctrl_go  <= 1'b0;
      send_req <= 1'b0;
      cfg_q    <= '0;
    end
    else
    begin
      // Address and data are taken together, one write in flight
      aw_ready <= wr_req.awvalid & wr_req.wvalid & ~b_valid & ~aw_ready;
      ctrl_go  <= wr_hs && (wr_req.awaddr == reg_ctrl) && wr_req.wdata[0];
      send_req <= ctrl_go;
      if (wr_hs)
      begin
        b_valid <= 1'b1;
        b_resp  <= addr_mapped(wr_req.awaddr) ? resp_okay : resp_slverr;
        case (wr_req.awaddr)
          reg_src_mac_hi: cfg_q.src_mac[47:32] <= mac_hi_merged[15:0];
          reg_src_mac_lo: cfg_q.src_mac[31:0]  <= mac_lo_merged;
          reg_src_ip:     cfg_q.src_ip         <= src_ip_merged;
          reg_dst_ip:     cfg_q.dst_ip         <= dst_ip_merged;
          default:        ;  // ctrl acts through ctrl_go, status is read only
        endcase
      end
      else if (wr_req.bready)
        b_valid <= 1'b0;
    end
  end

  assign status_word = {16'h0, frames_sent, 7'h0, busy};

  always_comb
  begin
    case (rd_req.araddr)
      reg_status:     rd_word = status_word;
      reg_src_mac_hi: rd_word = {16'h0, cfg_q.src_mac[47:32]};
      reg_src_mac_lo: rd_word = cfg_q.src_mac[31:0];
      reg_src_ip:     rd_word = cfg_q.src_ip;
      reg_dst_ip:     rd_word = cfg_q.dst_ip;
      default:        rd_word = '0;  // ctrl reads back as zero
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
      r_resp   <= resp_okay;
      r_data   <= '0;
    end
    else
    begin
      ar_ready <= rd_req.arvalid & ~r_valid & ~ar_ready;
      if (rd_hs)
      begin
        r_valid <= 1'b1;
        r_data  <= rd_word;
        r_resp  <= addr_mapped(rd_req.araddr) ? resp_okay : resp_slverr;
      end
      else if (rd_req.rready)
        r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      frames_sent <= '0;
    else if (frame_done)
      frames_sent <= frames_sent + 8'd1;  // Wraps at 256
  end

  always_comb
  begin
    wr_rsp.awready = aw_ready;
    wr_rsp.wready  = aw_ready;
    wr_rsp.bvalid  = b_valid;
    wr_rsp.bresp   = b_resp;
    rd_rsp.arready = ar_ready;
    rd_rsp.rvalid  = r_valid;
    rd_rsp.rdata   = r_data;
    rd_rsp.rresp   = r_resp;
  end

  assign cfg = cfg_q;

endmodule

/* source/arp_frame_sequencer.sv */
`timescale 1ns/1ps

module arp_frame_sequencer #(
  parameter int ifg_cycles = 12
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  arp_tx_pkg::arp_cfg_t cfg,
  input  logic                 send_req,
  output logic                 busy,
  output logic                 frame_done,
  output arp_tx_pkg::tx_byte_t tx_byte
);
  import arp_tx_pkg::*;

  localparam int cnt_max   = (ifg_cycles > pad_bytes) ? ifg_cycles : pad_bytes;
  localparam int cnt_w     = $clog2(cnt_max + 1);
  localparam int vec_bytes = 10;  // Longest field taken from a vector (sender MAC and IP)

  typedef logic [8*vec_bytes-1:0] field_vec_t;

  typedef enum logic [3:0] {
    st_idle,
    st_preamble,
    st_sfd,
    st_dst_mac,
    st_src_mac,
    st_ethertype,
    st_arp_hdr,
    st_sender,
    st_target,
    st_pad,
    st_fcs,
    st_gap
  } state_t;

  state_t           state;
  logic [cnt_w-1:0] cnt;
  logic             last_cnt;
  arp_cfg_t         cfg_q;
  field_vec_t       field_vec;
  int               byte_shift;

  // Number of cycles spent in each state
  function automatic int field_len(state_t s);
    case (s)
      st_preamble:  return preamble_bytes;
      st_sfd:       return 1;
      st_dst_mac:   return 6;
      st_src_mac:   return 6;
      st_ethertype: return 2;
      st_arp_hdr:   return 8;
      st_sender:    return 10;
      st_target:    return 10;
      st_pad:       return pad_bytes;
      st_fcs:       return 4;
      st_gap:       return ifg_cycles + 1;  // tx_en trails the last byte by one cycle
      default:      return 1;
    endcase
  endfunction

  function automatic state_t next_state(state_t s);
    case (s)
      st_preamble:  return st_sfd;
      st_sfd:       return st_dst_mac;
      st_dst_mac:   return st_src_mac;
      st_src_mac:   return st_ethertype;
      st_ethertype: return st_arp_hdr;
      st_arp_hdr:   return st_sender;
      st_sender:    return st_target;
      st_target:    return st_pad;
      st_pad:       return st_fcs;
      st_fcs:       return st_gap;
      default:      return st_idle;
    endcase
  endfunction

  assign last_cnt = (cnt == cnt_w'(field_len(state) - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= st_idle;
      cnt   <= '0;
    end
    else if (state == st_idle)
    begin
      cnt <= '0;
      if (send_req)
        state <= st_preamble;
    end
    else if (last_cnt)
    begin
      state <= next_state(state);
      cnt   <= '0;
    end
    else
      cnt <= cnt + 1'b1;
  end

  // Configuration is frozen for the whole frame
  always_ff @(posedge clk)
  begin
    if (state == st_idle && send_req)
      cfg_q <= cfg;
  end

  always_comb
  begin
    field_vec  = '0;
    byte_shift = 0;
    case (state)
      st_preamble:  field_vec = field_vec_t'({preamble_bytes{preamble_byte}});
      st_sfd:       field_vec = field_vec_t'(sfd_byte);
      st_dst_mac:   field_vec = field_vec_t'(broadcast_mac);
      st_src_mac:   field_vec = field_vec_t'(cfg_q.src_mac);
      st_ethertype: field_vec = field_vec_t'(ethertype_arp);
      st_arp_hdr:   field_vec = field_vec_t'(arp_hdr);
      st_sender:    field_vec = {cfg_q.src_mac, cfg_q.src_ip};
      st_target:    field_vec = {48'h0, cfg_q.dst_ip};  // Target MAC unknown in a request
      default:      field_vec = '0;
    endcase
    if (field_len(state) <= vec_bytes)
      byte_shift = 8 * (field_len(state) - 1 - int'(cnt));  // Most significant byte first

    tx_byte.valid     = (state != st_idle) && (state != st_gap);
    tx_byte.data      = field_vec[byte_shift +: 8];
    tx_byte.fcs_index = (state == st_fcs) ? cnt[1:0] : 2'd0;
    if (state == st_preamble || state == st_sfd)
      tx_byte.kind = kind_preamble;
    else if (state == st_fcs)
      tx_byte.kind = kind_fcs;
    else
      tx_byte.kind = kind_body;
  end

  assign busy       = (state != st_idle);
  assign frame_done = (state == st_fcs) && last_cnt;

endmodule

/* source/arp_fcs_output.sv */
`timescale 1ns/1ps

module arp_fcs_output (
  input  logic                 clk,
  input  logic                 rst_n,
  input  arp_tx_pkg::tx_byte_t tx_byte,
  output logic [3:0]           data_lo,
  output logic [3:0]           data_hi,
  output logic                 tx_en
);
  import arp_tx_pkg::*;

  localparam crc_t crc_poly   = 32'hEDB8_8320;  // Reflected IEEE 802.3 polynomial
  localparam crc_t crc_preset = 32'hFFFF_FFFF;

  crc_t       crc;
  crc_t       crc_inv;
  logic [7:0] out_byte;

  // One byte through the reflected CRC, bit 0 first as on the wire
  function automatic crc_t crc_byte(crc_t crc_in, logic [7:0] data);
    crc_t c;
    c = crc_in ^ {24'h0, data};
    for (int b = 0; b < 8; b++)
    begin
      if (c[0])
        c = (c >> 1) ^ crc_poly;
      else
        c = c >> 1;
    end
    return c;
  endfunction

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      crc <= crc_preset;
    else if (tx_byte.valid)
    begin
      case (tx_byte.kind)
        kind_preamble: crc <= crc_preset;  // Restart for every new frame
        kind_body:     crc <= crc_byte(crc, tx_byte.data);
        default:       crc <= crc;  // Hold while the FCS goes out
      endcase
    end
  end

  assign crc_inv = ~crc;

  always_comb
  begin
    if (tx_byte.kind == kind_fcs)
      out_byte = crc_inv[8*tx_byte.fcs_index +: 8];  // Least significant byte first
    else
      out_byte = tx_byte.data;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      tx_en <= 1'b0;
    else
      tx_en <= tx_byte.valid;
  end

  // Low nibble goes out on the rising half of the DDR cell
  always_ff @(posedge clk)
  begin
    data_lo <= out_byte[3:0];
    data_hi <= out_byte[7:4];
  end

endmodule

/* source/arp_tx_top.sv */
`timescale 1ns/1ps

module arp_tx_top #(
  parameter int ifg_cycles = 12
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  arp_tx_pkg::axil_wr_req_t wr_req,
  output arp_tx_pkg::axil_wr_rsp_t wr_rsp,
  input  arp_tx_pkg::axil_rd_req_t rd_req,
  output arp_tx_pkg::axil_rd_rsp_t rd_rsp,
  output logic [3:0]               data_lo,
  output logic [3:0]               data_hi,
  output logic                     tx_en
);
  import arp_tx_pkg::*;

  arp_cfg_t cfg;
  logic     send_req;
  logic     busy;
  logic     frame_done;
  tx_byte_t tx_byte;

  arp_csr_decode u_csr (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_req     (wr_req),
    .wr_rsp     (wr_rsp),
    .rd_req     (rd_req),
    .rd_rsp     (rd_rsp),
    .busy       (busy),
    .frame_done (frame_done),
    .cfg        (cfg),
    .send_req   (send_req)
  );

  arp_frame_sequencer #(
    .ifg_cycles (ifg_cycles)
  ) u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .send_req   (send_req),
    .busy       (busy),
    .frame_done (frame_done),
    .tx_byte    (tx_byte)
  );

  arp_fcs_output u_fcs (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_byte (tx_byte),
    .data_lo (data_lo),
    .data_hi (data_hi),
    .tx_en   (tx_en)
  );

endmodule

/* dv/arp_tx_tb_checks.svh */
localparam int body_bytes = frame_bytes - preamble_bytes - 1 - 4;  // Destination MAC up to pad

typedef logic [8*frame_bytes-1:0] frame_vec_t;  // Byte i of the wire order at bits 8*i+7:8*i

// Taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_step(logic [31:0] state);
  return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// Serial CRC-32 taking one data bit per step with bit 0 first
function automatic crc_t crc32_update(crc_t crc, logic [7:0] data);
  logic fb;
  for (int i = 0; i < 8; i++)
  begin
    fb  = crc[0] ^ data[i];
    crc = {1'b0, crc[31:1]};
    if (fb)
      crc = crc ^ 32'hEDB8_8320;
  end
  return crc;
endfunction

function automatic frame_vec_t build_expected(arp_cfg_t c);
  logic [8*body_bytes-1:0] body;
  frame_vec_t              frame;
  crc_t                    crc;
  body = {broadcast_mac, c.src_mac, ethertype_arp, arp_hdr, c.src_mac, c.src_ip,
          48'h0, c.dst_ip, {(8*pad_bytes){1'b0}}};
  crc   = 32'hFFFF_FFFF;
  frame = '0;
  for (int i = 0; i < preamble_bytes; i++)
    frame[8*i +: 8] = preamble_byte;
  frame[8*preamble_bytes +: 8] = sfd_byte;
  for (int i = 0; i < body_bytes; i++)
  begin
    frame[8*(preamble_bytes + 1 + i) +: 8] = body[8*(body_bytes - 1 - i) +: 8];
    crc = crc32_update(crc, body[8*(body_bytes - 1 - i) +: 8]);
  end
  crc = ~crc;
  for (int i = 0; i < 4; i++)
    frame[8*(frame_bytes - 4 + i) +: 8] = crc[8*i +: 8];  // FCS leaves least significant byte first
  return frame;
endfunction

task automatic stop_on_error();
  $display("ERRORS FOUND");
  $fatal(1);
endtask

task automatic check_equal(string name, logic [63:0] got, logic [63:0] expected);
  if (got !== expected)
  begin
    $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected);
    stop_on_error();
  end
endtask

/* dv/arp_tx_tb.sv */
`timescale 1ns/1ps

module arp_tx_tb;
  import arp_tx_pkg::*;

  `include "arp_tx_tb_checks.svh"

  localparam int ifg_cycles     = 12;
  localparam int num_frames     = 8;  // Seven frames plus the idle window of the busy test
  localparam int timeout_cycles = num_frames * (frame_bytes + ifg_cycles + 40) + 300;

  logic         clk = 1'b0;
  logic         rst_n;
  axil_wr_req_t wr_req;
  axil_wr_rsp_t wr_rsp;
  axil_rd_req_t rd_req;
  axil_rd_rsp_t rd_rsp;
  logic [3:0]   data_lo;
  logic [3:0]   data_hi;
  logic         tx_en;

  int          cycle = 0;
  int          wr_cycle;  // Edge of the last write handshake
  logic [31:0] lfsr = 32'h2a5a_15a9;
  frame_vec_t  rx_cur;
  frame_vec_t  rx_frame;
  int          rx_len = 0;
  int          rx_frame_len;
  int          rx_start;
  int          rx_frame_start;
  int          rx_end = 0;
  int          rx_gap;
  int          frame_count = 0;
  int          frames_checked = 0;

  always #2 clk = ~clk;

  arp_tx_top #(
    .ifg_cycles (ifg_cycles)
  ) dut_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_req  (wr_req),
    .wr_rsp  (wr_rsp),
    .rd_req  (rd_req),
    .rd_rsp  (rd_rsp),
    .data_lo (data_lo),
    .data_hi (data_hi),
    .tx_en   (tx_en)
  );

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
      stop_on_error();
    end
  end

  // Frame monitor collecting one byte per cycle with tx_en high
  always @(posedge clk)
  begin
    if (tx_en)
    begin
      if (rx_len == 0)
      begin
        rx_start = cycle - 1;  // tx_en rose on the previous edge
        rx_gap   = rx_start - rx_end;
      end
      if (rx_len < frame_bytes)
        rx_cur[8*rx_len +: 8] = {data_hi, data_lo};
      rx_len++;
    end
    else if (rx_len != 0)
    begin
      rx_frame       = rx_cur;
      rx_frame_len   = rx_len;
      rx_frame_start = rx_start;
      rx_end         = cycle - 1;
      rx_len         = 0;
      frame_count++;
    end
  end

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_strb_t strb, output axil_resp_t resp);
    @(posedge clk);
    wr_req.awvalid <= 1'b1;
    wr_req.awaddr  <= addr;
    wr_req.wvalid  <= 1'b1;
    wr_req.wdata   <= data;
    wr_req.wstrb   <= strb;
    wr_req.bready  <= 1'b1;
    @(posedge clk);
    while (!wr_rsp.awready)
      @(posedge clk);
    check_equal("wready", 64'(wr_rsp.wready), 64'(1));
    wr_cycle = cycle;
    wr_req.awvalid <= 1'b0;
    wr_req.wvalid  <= 1'b0;
    @(posedge clk);
    while (!wr_rsp.bvalid)
      @(posedge clk);
    resp = wr_rsp.bresp;
    wr_req.bready <= 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                           output axil_resp_t resp);
    @(posedge clk);
    rd_req.arvalid <= 1'b1;
    rd_req.araddr  <= addr;
    rd_req.rready  <= 1'b1;
    @(posedge clk);
    while (!rd_rsp.arready)
      @(posedge clk);
    rd_req.arvalid <= 1'b0;
    @(posedge clk);
    while (!rd_rsp.rvalid)
      @(posedge clk);
    data = rd_rsp.rdata;
    resp = rd_rsp.rresp;
    rd_req.rready <= 1'b0;
  endtask

  task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb);
    axil_resp_t resp;
    axil_write(addr, data, strb, resp);
    check_equal($sformatf("bresp at 0x%0h", addr), 64'(resp), 64'(resp_okay));
  endtask

  task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
    axil_resp_t resp;
    axil_read(addr, data, resp);
    check_equal($sformatf("rresp at 0x%0h", addr), 64'(resp), 64'(resp_okay));
  endtask

  task automatic configure(input arp_cfg_t c);
    write_reg(reg_src_mac_hi, {16'h0, c.src_mac[47:32]}, 4'hF);
    write_reg(reg_src_mac_lo, c.src_mac[31:0], 4'hF);
    write_reg(reg_src_ip, c.src_ip, 4'hF);
    write_reg(reg_dst_ip, c.dst_ip, 4'hF);
  endtask

  task automatic send_frame();
    write_reg(reg_ctrl, 32'h1, 4'hF);
  endtask

  task automatic wait_idle();
    axil_data_t status;
    read_reg(reg_status, status);
    while (status[0])
      read_reg(reg_status, status);
  endtask

  task automatic random_bits(input int n, output logic [47:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v    = {v[46:0], lfsr[0]};
    end
  endtask

  // Waits for the next complete frame from the monitor and checks every byte
  task automatic capture_frame(input arp_cfg_t c);
    frame_vec_t expected;
    expected = build_expected(c);
    wait (frame_count > frames_checked);
    frames_checked++;
    check_equal("frame length", 64'(rx_frame_len), 64'(frame_bytes));
    for (int i = 0; i < frame_bytes; i++)
      check_equal($sformatf("frame byte %0d", i), 64'(rx_frame[8*i +: 8]),
                  64'(expected[8*i +: 8]));
  endtask

  task automatic reset_and_registers();
    axil_data_t data;
    axil_resp_t resp;
    check_equal("tx_en", 64'(tx_en), 64'(0));
    read_reg(reg_status, data);
    check_equal("status", 64'(data), 64'(0));
    write_reg(reg_src_mac_hi, 32'hFFFF_1234, 4'hF);
    write_reg(reg_src_mac_lo, 32'h5678_9ABC, 4'hF);
    write_reg(reg_src_ip, 32'h1122_3344, 4'hF);
    write_reg(reg_dst_ip, 32'h5566_7788, 4'hF);
    write_reg(reg_src_ip, 32'hAABB_CCDD, 4'b0101);  // Only bytes 0 and 2 change
    read_reg(reg_src_mac_hi, data);
    check_equal("src_mac_hi", 64'(data), 64'(32'h0000_1234));
    read_reg(reg_src_mac_lo, data);
    check_equal("src_mac_lo", 64'(data), 64'(32'h5678_9ABC));
    read_reg(reg_src_ip, data);
    check_equal("src_ip", 64'(data), 64'(32'h11BB_33DD));
    read_reg(reg_dst_ip, data);
    check_equal("dst_ip", 64'(data), 64'(32'h5566_7788));
    axil_write(8'h18, 32'h1, 4'hF, resp);
    check_equal("bresp unmapped", 64'(resp), 64'(resp_slverr));
    axil_read(8'h18, data, resp);
    check_equal("rresp unmapped", 64'(resp), 64'(resp_slverr));
    check_equal("rdata unmapped", 64'(data), 64'(0));
  endtask

  task automatic fixed_address_frame();
    arp_cfg_t c;
    c.src_mac = 48'hAC16_2DBB_53A1;
    c.src_ip  = 32'hC0A8_000B;  // 192.168.0.11
    c.dst_ip  = 32'hC0A8_0090;  // 192.168.0.144
    configure(c);
    send_frame();
    capture_frame(c);
    check_equal("tx_en rise cycle", 64'(rx_frame_start), 64'(wr_cycle + 3));
  endtask

  task automatic random_frames();
    arp_cfg_t    c;
    logic [47:0] bits;
    for (int n = 0; n < 3; n++)
    begin
      random_bits(48, bits);
      c.src_mac = bits;
      random_bits(32, bits);
      c.src_ip = bits[31:0];
      random_bits(32, bits);
      c.dst_ip = bits[31:0];
      wait_idle();
      configure(c);
      send_frame();
      capture_frame(c);
    end
  endtask

  task automatic send_while_busy();
    arp_cfg_t   c;
    axil_data_t status;
    logic [7:0] sent_before;
    int         count_before;
    wait_idle();
    read_reg(reg_status, status);
    sent_before  = status[15:8];
    count_before = frame_count;
    c.src_mac = 48'h0200_0000_0001;
    c.src_ip  = 32'h0A00_0001;
    c.dst_ip  = 32'h0A00_00FE;
    configure(c);
    send_frame();
    wait (tx_en);
    send_frame();  // Lands while the frame is on the wire
    read_reg(reg_status, status);
    check_equal("status busy", 64'(status[0]), 64'(1));
    capture_frame(c);
    wait_idle();
    repeat (frame_bytes + ifg_cycles) @(posedge clk);
    check_equal("frame count", 64'(frame_count), 64'(count_before + 1));
    read_reg(reg_status, status);
    check_equal("frames_sent", 64'(status[15:8]), 64'(sent_before + 8'd1));
  endtask

  task automatic config_latching();
    arp_cfg_t first;
    arp_cfg_t second;
    first.src_mac = 48'h0200_0000_0002;
    first.src_ip  = 32'hC0A8_0101;
    first.dst_ip  = 32'hC0A8_01FE;
    second        = first;
    second.src_ip = 32'hC0A8_0177;
    wait_idle();
    configure(first);
    send_frame();
    wait (tx_en);
    write_reg(reg_src_ip, second.src_ip, 4'hF);
    capture_frame(first);
    wait_idle();
    send_frame();
    capture_frame(second);
    if (rx_gap < ifg_cycles)
    begin
      $display("tx_en was low for only %0d cycles between two frames", rx_gap);
      stop_on_error();
    end
  endtask

  initial
  begin
    rst_n  = 1'b0;
    wr_req = '0;
    rd_req = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    reset_and_registers();
    fixed_address_frame();
    random_frames();
    send_while_busy();
    config_latching();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* arp_tx.f */
+incdir+dv
source/arp_tx_pkg.sv
source/arp_csr_decode.sv
source/arp_frame_sequencer.sv
source/arp_fcs_output.sv
source/arp_tx_top.sv
dv/arp_tx_tb.sv

/* Makefile */
# Verilator build and run of the ARP transmitter testbench

SIM_DIR := obj_dir

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module arp_tx_tb -Mdir $(SIM_DIR) -f arp_tx.f
	@out=$$(./$(SIM_DIR)/Varp_tx_tb); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	verilator --lint-only -Wall --timing --top-module arp_tx_tb -f arp_tx.f

clean:
	rm -rf $(SIM_DIR)
